// File: filelist.f
uart_pkg.sv
cmd_sequencer.sv
uart_tx.sv
uart_rx.sv
read_checker.sv
uart_link.sv
uart_link_sva.sv
uart_scoreboard.sv
tb_uart_link.sv

// File: run.sh
#!/bin/sh
# build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert -f filelist.f --top-module tb_uart_link -o sim_uart_link \
  > build.log 2>&1 \
  && ./obj_dir/sim_uart_link > sim.log 2>&1 \
  || { cat build.log sim.log 2>/dev/null; echo "build or run failed"; exit 1; }
cat sim.log
! grep -q "ERRORS FOUND" sim.log && grep -q "NO ERRORS" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// File: tb_uart_link.sv
`timescale 1ns/1ps
`default_nettype none

module tb_uart_link;

  localparam int n_cmds = 12;
  localparam int n_frames = 20;
  localparam int frame_cycles = uart_pkg::frame_bits * uart_pkg::clks_per_bit;
  localparam int limit_cycles = (n_cmds + n_frames) * 2 * frame_cycles * 2;

  logic        clk;
  logic        rst_n;
  logic [15:0] cmd_in;
  logic        cmd_vld;
  logic        rx_drv;
  logic        loopback;
  logic        rx_line;
  logic        end_check;
  logic        tx;
  logic        cmd_rdy;
  logic [8:0]  read_data;
  logic        read_rdy;
  int          err_count;
  int          test_count;
  int          pending;
  logic [31:0] lfsr;

  // phase 1 loops tx back, phase 2 drives rx directly
  assign rx_line = loopback ? tx : rx_drv;

  uart_link UUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .rx        (rx_line),
    .tx        (tx),
    .cmd_rdy   (cmd_rdy),
    .read_data (read_data),
    .read_rdy  (read_rdy)
  );

  uart_scoreboard u_sb (
    .clk        (clk),
    .rst_n      (rst_n),
    .cmd_in     (cmd_in),
    .cmd_vld    (cmd_vld),
    .cmd_rdy    (cmd_rdy),
    .tx         (tx),
    .rx         (rx_line),
    .loopback   (loopback),
    .read_data  (read_data),
    .read_rdy   (read_rdy),
    .end_check  (end_check),
    .err_count  (err_count),
    .test_count (test_count),
    .pending    (pending)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  // galois lfsr, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int k = 0; k < n; k++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
      r = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  function automatic logic odd_parity(input logic [7:0] b);
    logic p;
    p = 1'b1;
    for (int k = 0; k < 8; k++) begin
      p = p ^ b[k];
    end
    return p;
  endfunction

  task automatic send_cmd();
    logic [31:0] r;
    int          gap;
    r   = rand_bits(3);
    gap = r;
    repeat (gap) @(posedge clk);
    while (!cmd_rdy) @(posedge clk);
    r = rand_bits(16);
    cmd_in  <= r[15:0];
    cmd_vld <= 1'b1;
    @(posedge clk);
    cmd_vld <= 1'b0;
    // stray strobes while busy must be ignored
    repeat (4) begin
      r   = rand_bits(4);
      gap = r + 1;
      repeat (gap) @(posedge clk);
      r = rand_bits(17);
      cmd_in  <= r[15:0];
      cmd_vld <= r[16];
      @(posedge clk);
      cmd_vld <= 1'b0;
    end
  endtask

  task automatic drive_frame();
    logic [31:0]                     r;
    logic [7:0]                      b;
    logic                            par;
    logic                            stop;
    logic [uart_pkg::frame_bits-1:0] bits;
    int                              gap;
    r    = rand_bits(8);
    b    = r[7:0];
    r    = rand_bits(2);
    par  = odd_parity(b);
    stop = 1'b1;
    if (r[1:0] == 2'd0) begin
      par = ~par;
    end else if (r[1:0] == 2'd1) begin
      stop = 1'b0;
    end
    bits = {stop, par, b, 1'b0};
    r    = rand_bits(3);
    gap  = r + 1;
    for (int k = 0; k < uart_pkg::frame_bits; k++) begin
      rx_drv <= bits[k];
      repeat (uart_pkg::clks_per_bit) @(posedge clk);
    end
    rx_drv <= 1'b1;
    repeat (gap) @(posedge clk);
  endtask

  task automatic wait_idle();
    @(posedge clk);
    while (pending != 0 || !cmd_rdy) @(posedge clk);
  endtask

  initial begin
    lfsr      = 32'h014d0f56;
    rst_n     = 1'b0;
    cmd_in    = '0;
    cmd_vld   = 1'b0;
    rx_drv    = 1'b1;
    loopback  = 1'b1;
    end_check = 1'b0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    repeat (4) @(posedge clk);
    for (int n = 0; n < n_cmds; n++) begin
      send_cmd();
    end
    wait_idle();
    loopback <= 1'b0;
    for (int n = 0; n < n_frames; n++) begin
      drive_frame();
    end
    wait_idle();
    end_check <= 1'b1;
    @(posedge clk);
    end_check <= 1'b0;
    repeat (2) @(posedge clk);
    $display("tests %0d, errors %0d", test_count, err_count);
    if (err_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  // watchdog
  initial begin
    repeat (limit_cycles) @(posedge clk);
    $display("timeout: the run did not finish within %0d cycles", limit_cycles);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

`default_nettype wire

// File: uart_scoreboard.sv
`timescale 1ns/1ps
`default_nettype none

module uart_scoreboard (
  input  wire logic        clk,
  input  wire logic        rst_n,
  input  wire logic [15:0] cmd_in,
  input  wire logic        cmd_vld,
  input  wire logic        cmd_rdy,
  input  wire logic        tx,
  input  wire logic        rx,
  input  wire logic        loopback,
  input  wire logic [8:0]  read_data,
  input  wire logic        read_rdy,
  input  wire logic        end_check,
  output int               err_count,
  output int               test_count,
  output int               pending
);

  localparam int bit_clks = uart_pkg::clks_per_bit;
  localparam int mid_cnt = uart_pkg::clks_per_bit / 2 - 1;
  localparam int last_bit = uart_pkg::frame_bits - 1;
  // start delay, two frames, one load gap
  localparam int rdy_cycles = 2 + 2 * uart_pkg::frame_bits * uart_pkg::clks_per_bit + 2;

  uart_pkg::byte_t                 tx_q[$];
  uart_pkg::read_word_t            rd_q[$];
  logic [1:0]                      line_prev;
  logic [1:0]                      line_busy;
  int                              line_cnt [2];
  logic [uart_pkg::frame_bits-1:0] line_bits [2];
  logic                            reset_checked;
  logic                            rdy_track;
  int                              rdy_cnt;

  function automatic logic odd_parity(input uart_pkg::byte_t b);
    int ones;
    ones = 0;
    for (int k = 0; k < 8; k++) begin
      ones = ones + (b[k] ? 1 : 0);
    end
    return (ones % 2 == 0);
  endfunction

  task automatic check_tx_frame(input logic [uart_pkg::frame_bits-1:0] got);
    uart_pkg::byte_t                 exp_byte;
    logic [uart_pkg::frame_bits-1:0] exp_bits;
    if (tx_q.size() == 0) begin
      $display("unexpected frame on tx carrying byte %h", got[8:1]);
      err_count++;
    end else begin
      exp_byte = tx_q.pop_front();
      exp_bits = {1'b1, odd_parity(exp_byte), exp_byte, 1'b0};
      for (int k = 0; k < uart_pkg::frame_bits; k++) begin
        if (got[k] !== exp_bits[k]) begin
          $display("Mismatch tx bit %0d: got %h expected %h", k, got[k], exp_bits[k]);
          err_count++;
        end
      end
    end
  endtask

  // looped back reads carry the accepted command, high byte first
  task automatic queue_loopback_reads(input logic [15:0] cmd);
    uart_pkg::read_word_t w;
    w.error = 1'b0;
    w.data  = cmd[15:8];
    rd_q.push_back(w);
    w.data  = cmd[7:0];
    rd_q.push_back(w);
  endtask

  // expected read for a frame seen on rx
  task automatic model_read(input logic [uart_pkg::frame_bits-1:0] got);
    uart_pkg::read_word_t w;
    w.data  = got[8:1];
    w.error = (got[9] != odd_parity(got[8:1])) || !got[10];
    rd_q.push_back(w);
  endtask

  task automatic check_read();
    uart_pkg::read_word_t exp_word;
    test_count++;
    if (rd_q.size() == 0) begin
      $display("test %0d failed: read_rdy pulsed with no frame on rx", test_count);
      err_count++;
    end else begin
      exp_word = rd_q.pop_front();
      if (read_data !== exp_word) begin
        $display("Mismatch read_data: got %h expected %h", read_data, exp_word);
        $display("test %0d failed", test_count);
        err_count++;
      end else begin
        $display("test %0d passed: read_data %h", test_count, read_data);
      end
    end
  endtask

  always @(posedge clk) begin
    logic [1:0] cur;
    logic       exp_rdy;
    if (!rst_n) begin
      tx_q.delete();
      rd_q.delete();
      line_prev     = 2'b11;
      line_busy     = 2'b00;
      reset_checked = 1'b0;
      rdy_track     = 1'b0;
      rdy_cnt       = 0;
      err_count     = 0;
      test_count    = 0;
    end else begin
      if (!reset_checked) begin
        reset_checked = 1'b1;
        if (tx !== 1'b1 || cmd_rdy !== 1'b1 || read_rdy !== 1'b0) begin
          $display("reset state wrong: tx %h cmd_rdy %h read_rdy %h", tx, cmd_rdy, read_rdy);
          err_count++;
        end else begin
          $display("reset state check passed");
        end
      end

      if (rdy_track) begin
        rdy_cnt++;
        exp_rdy = (rdy_cnt == rdy_cycles + 1);
        if (cmd_rdy !== exp_rdy) begin
          $display("Mismatch cmd_rdy %0d cycles after accept: got %h expected %h",
                   rdy_cnt - 1, cmd_rdy, exp_rdy);
          err_count++;
        end
        if (rdy_cnt == rdy_cycles + 1) begin
          rdy_track = 1'b0;
        end
      end
      if (cmd_vld && cmd_rdy) begin
        tx_q.push_back(cmd_in[15:8]);
        tx_q.push_back(cmd_in[7:0]);
        if (loopback) begin
          queue_loopback_reads(cmd_in);
        end
        rdy_track = 1'b1;
        rdy_cnt   = 0;
      end

      // index 0 watches tx, index 1 watches rx
      cur = {rx, tx};
      for (int i = 0; i < 2; i++) begin
        if (!line_busy[i]) begin
          if (line_prev[i] && !cur[i]) begin
            line_busy[i] = 1'b1;
            line_cnt[i]  = 0;
          end
        end else begin
          line_cnt[i]++;
        end
        if (line_busy[i] && (line_cnt[i] % bit_clks == mid_cnt)) begin
          line_bits[i][line_cnt[i] / bit_clks] = cur[i];
          if (line_cnt[i] / bit_clks == last_bit) begin
            line_busy[i] = 1'b0;
            if (i == 0) begin
              check_tx_frame(line_bits[i]);
            end else if (!loopback) begin
              model_read(line_bits[i]);
            end
          end
        end
        line_prev[i] = cur[i];
      end

      if (read_rdy) begin
        check_read();
      end

      if (end_check && (tx_q.size() != 0 || rd_q.size() != 0)) begin
        $display("frames still outstanding at the end: %0d on tx, %0d reads",
                 tx_q.size(), rd_q.size());
        err_count++;
      end
    end
    pending <= tx_q.size() + rd_q.size() + ((line_busy != 2'b00) ? 1 : 0);
  end

endmodule

`default_nettype wire

// File: uart_link_sva.sv
`timescale 1ns/1ps
`default_nettype none

module uart_link_sva (
  input wire logic clk,
  input wire logic rst_n,
  input wire logic cmd_vld,
  input wire logic cmd_rdy,
  input wire logic tx,
  input wire logic read_rdy
);

  // busy straight after a command is taken
  rdy_drop: assert property (@(posedge clk) disable iff (!rst_n)
    (cmd_vld && cmd_rdy) |=> !cmd_rdy)
    else $error("cmd_rdy still high in the cycle after acceptance");

  read_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    read_rdy |=> !read_rdy)
    else $error("read_rdy high for two cycles in a row");

  // line idles high while nothing is queued
  idle_line: assert property (@(posedge clk) disable iff (!rst_n)
    cmd_rdy |-> tx)
    else $error("tx low while cmd_rdy is high");

endmodule

bind uart_link uart_link_sva u_sva (
  .clk      (clk),
  .rst_n    (rst_n),
  .cmd_vld  (cmd_vld),
  .cmd_rdy  (cmd_rdy),
  .tx       (tx),
  .read_rdy (read_rdy)
);

`default_nettype wire

// File: uart_link.sv
`timescale 1ns/1ps
`default_nettype none

module uart_link (
  input  wire logic                           clk,
  input  wire logic                           rst_n,
  input  wire logic [uart_pkg::cmd_width-1:0] cmd_in,
  input  wire logic                           cmd_vld,
  input  wire logic                           rx,
  output logic                                tx,
  output logic                                cmd_rdy,
  output logic [8:0]                          read_data,
  output logic                                read_rdy
);

  logic                tx_load;
  uart_pkg::byte_t     tx_byte;
  logic                tx_busy;
  uart_pkg::rx_frame_t frame;
  logic                frame_vld;

  cmd_sequencer u_seq (
    .clk     (clk),
    .rst_n   (rst_n),
    .cmd_in  (cmd_in),
    .cmd_vld (cmd_vld),
    .tx_busy (tx_busy),
    .cmd_rdy (cmd_rdy),
    .tx_load (tx_load),
    .tx_byte (tx_byte)
  );

  uart_tx u_tx (
    .clk     (clk),
    .rst_n   (rst_n),
    .tx_load (tx_load),
    .tx_byte (tx_byte),
    .tx      (tx),
    .tx_busy (tx_busy)
  );

  uart_rx u_rx (
    .clk       (clk),
    .rst_n     (rst_n),
    .rx        (rx),
    .frame     (frame),
    .frame_vld (frame_vld)
  );

  read_checker u_chk (
    .clk       (clk),
    .rst_n     (rst_n),
    .frame     (frame),
    .frame_vld (frame_vld),
    .read_data (read_data),
    .read_rdy  (read_rdy)
  );

endmodule

`default_nettype wire

// File: read_checker.sv
`timescale 1ns/1ps
`default_nettype none

module read_checker (
  input  wire logic                clk,
  input  wire logic                rst_n,
  input  wire uart_pkg::rx_frame_t frame,
  input  wire logic                frame_vld,
  output uart_pkg::read_word_t     read_data,
  output logic                     read_rdy
);

  logic bad;

  // odd parity over data and parity bit, stop must be high
  assign bad = ~(^{frame.data, frame.parity}) | ~frame.stop;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      read_rdy <= 1'b0;
    end else begin
      read_rdy <= frame_vld;
    end
  end

  // held until the next frame
  always_ff @(posedge clk) begin
    if (frame_vld) begin
      read_data.error <= bad;
      read_data.data  <= frame.data;
    end
  end

endmodule

`default_nettype wire

// File: uart_rx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx (
  input  wire logic           clk,
  input  wire logic           rst_n,
  input  wire logic           rx,
  output uart_pkg::rx_frame_t frame,
  output logic                frame_vld
);

  uart_pkg::rx_state_e             state;
  uart_pkg::cnt_t                  bit_cnt;
  logic [2:0]                      bit_idx;
  logic                            rx_meta;
  logic                            rx_sync;
  logic                            rx_prev;
  logic [uart_pkg::frame_bits-2:0] shreg;
  logic                            sample;

  // two-flop sync, third flop for the edge
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  assign sample = (bit_cnt == uart_pkg::bit_last);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= uart_pkg::rx_idle;
      bit_cnt   <= '0;
      bit_idx   <= '0;
      frame_vld <= 1'b0;
    end else begin
      frame_vld <= 1'b0;
      bit_cnt   <= sample ? '0 : bit_cnt + 1'b1;
      case (state)
        uart_pkg::rx_idle: begin
          bit_cnt <= '0;
          bit_idx <= '0;
          if (rx_prev & ~rx_sync) begin
            state <= uart_pkg::rx_start;
          end
        end
        uart_pkg::rx_start: begin
          // half a bit in, the line must still be low
          if (bit_cnt == uart_pkg::half_last) begin
            bit_cnt <= '0;
            state   <= rx_sync ? uart_pkg::rx_idle : uart_pkg::rx_data;
          end
        end
        uart_pkg::rx_data: begin
          if (sample) begin
            bit_idx <= bit_idx + 3'd1;
            if (bit_idx == 3'd7) begin
              state <= uart_pkg::rx_parity;
            end
          end
        end
        uart_pkg::rx_parity: begin
          if (sample) begin
            state <= uart_pkg::rx_stop;
          end
        end
        uart_pkg::rx_stop: begin
          if (sample) begin
            state     <= uart_pkg::rx_idle;
            frame_vld <= 1'b1;
          end
        end
        default: state <= uart_pkg::rx_idle;
      endcase
    end
  end

  // data, parity, stop arrive lsb first
  always_ff @(posedge clk) begin
    if (sample && (state inside {uart_pkg::rx_data, uart_pkg::rx_parity,
                                 uart_pkg::rx_stop})) begin
      shreg <= {rx_sync, shreg[uart_pkg::frame_bits-2:1]};
    end
  end

  always_comb begin
    frame.data   = shreg[7:0];
    frame.parity = shreg[8];
    frame.stop   = shreg[uart_pkg::frame_bits-2];
  end

endmodule

`default_nettype wire

// File: uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
  input  wire logic            clk,
  input  wire logic            rst_n,
  input  wire logic            tx_load,
  input  wire uart_pkg::byte_t tx_byte,
  output logic                 tx,
  output logic                 tx_busy
);

  uart_pkg::tx_state_e              state;
  uart_pkg::cnt_t                   bit_cnt;
  logic [2:0]                       bit_idx;
  logic [uart_pkg::frame_bits-1:0]  frame_q;
  logic                             bit_end;

  assign bit_end = (bit_cnt == uart_pkg::bit_last);

  // line idles high, ones shift in behind the frame
  assign tx = frame_q[0];
  assign tx_busy = (state != uart_pkg::tx_idle);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= uart_pkg::tx_idle;
      bit_cnt <= '0;
      bit_idx <= '0;
      frame_q <= '1;
    end else if (state == uart_pkg::tx_idle) begin
      bit_cnt <= '0;
      bit_idx <= '0;
      if (tx_load) begin
        // stop, odd parity, data, start
        frame_q <= {1'b1, ~^tx_byte, tx_byte, 1'b0};
        state   <= uart_pkg::tx_start;
      end
    end else begin
      bit_cnt <= bit_end ? '0 : bit_cnt + 1'b1;
      if (bit_end) begin
        frame_q <= {1'b1, frame_q[uart_pkg::frame_bits-1:1]};
        case (state)
          uart_pkg::tx_start: begin
            state <= uart_pkg::tx_data;
          end
          uart_pkg::tx_data: begin
            bit_idx <= bit_idx + 3'd1;
            if (bit_idx == 3'd7) begin
              state <= uart_pkg::tx_parity;
            end
          end
          uart_pkg::tx_parity: begin
            state <= uart_pkg::tx_stop;
          end
          uart_pkg::tx_stop: begin
            state <= uart_pkg::tx_idle;
          end
          default: state <= uart_pkg::tx_idle;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

// File: cmd_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_sequencer (
  input  wire logic                           clk,
  input  wire logic                           rst_n,
  input  wire logic [uart_pkg::cmd_width-1:0] cmd_in,
  input  wire logic                           cmd_vld,
  input  wire logic                           tx_busy,
  output logic                                cmd_rdy,
  output logic                                tx_load,
  output uart_pkg::byte_t                     tx_byte
);

  uart_pkg::seq_state_e           state;
  logic [uart_pkg::cmd_width-1:0] cmd_q;
  logic                           busy_q;
  logic                           busy_fall;
  logic                           accept;
  logic                           load_now;

  // a frame has just finished
  assign busy_fall = busy_q & ~tx_busy;

  // ready again in the very cycle the low frame completes
  assign cmd_rdy = (state == uart_pkg::seq_idle) |
                   ((state == uart_pkg::seq_low) & busy_fall);
  assign accept = cmd_vld & cmd_rdy;

  // high byte on entry, low byte as the high frame ends
  assign load_now = (state == uart_pkg::seq_high) & ~tx_busy & ~tx_load;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state  <= uart_pkg::seq_idle;
      busy_q <= 1'b0;
    end else begin
      busy_q <= tx_busy;
      if (accept) begin
        state <= uart_pkg::seq_high;
      end else begin
        case (state)
          uart_pkg::seq_high: begin
            if (busy_fall) begin
              state <= uart_pkg::seq_low;
            end
          end
          uart_pkg::seq_low: begin
            if (busy_fall) begin
              state <= uart_pkg::seq_idle;
            end
          end
          default: state <= uart_pkg::seq_idle;
        endcase
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tx_load <= 1'b0;
    end else begin
      tx_load <= load_now;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      cmd_q <= cmd_in;
    end
    if (load_now) begin
      tx_byte <= busy_fall ? cmd_q[7:0] : cmd_q[uart_pkg::cmd_width-1 -: 8];
    end
  end

endmodule

`default_nettype wire

// File: uart_pkg.sv
`default_nettype none

package uart_pkg;

  // bit timing, kept short for simulation
  localparam int clks_per_bit = 8;
  localparam int frame_bits = 11;
  localparam int cmd_width = 16;
  localparam int cnt_width = $clog2(clks_per_bit);

  typedef logic [cnt_width-1:0] cnt_t;

  localparam cnt_t bit_last = cnt_t'(clks_per_bit - 1);
  localparam cnt_t half_last = cnt_t'(clks_per_bit / 2 - 1);

  typedef logic [7:0] byte_t;

  typedef enum logic [2:0] {
    tx_idle,
    tx_start,
    tx_data,
    tx_parity,
    tx_stop
  } tx_state_e;

  typedef enum logic [2:0] {
    rx_idle,
    rx_start,
    rx_data,
    rx_parity,
    rx_stop
  } rx_state_e;

  typedef enum logic [1:0] {
    seq_idle,
    seq_high,
    seq_low
  } seq_state_e;

  typedef struct packed {
    byte_t data;
    logic  parity;
    logic  stop;
  } rx_frame_t;

  // maps straight onto read_data
  typedef struct packed {
    logic  error;
    byte_t data;
  } read_word_t;

endpackage

`default_nettype wire
